//--- logic/rename_params_pkg.sv
package rename_params_pkg;

  // ******************************
  // register file sizes.
  // ******************************
  localparam int num_ar = 32;
  localparam int num_pr = 64;
  localparam int num_fl = 32;
  localparam int rob_depth = 8;

  // architectural r0 is hardwired to physical p0.
  localparam int zero_reg = 0;
  localparam int zero_pr = 0;

  // ******************************
  // index widths.
  // ******************************
  localparam int ar_bits = $clog2(num_ar);
  localparam int pr_bits = $clog2(num_pr);
  localparam int fl_bits = $clog2(num_fl);
  localparam int rob_bits = $clog2(rob_depth);

endpackage

//--- logic/rename_types_pkg.sv
package rename_types_pkg;

  // ******************************
  // register indices.
  // ******************************
  typedef logic [rename_params_pkg::ar_bits-1:0] areg_t;
  typedef logic [rename_params_pkg::pr_bits-1:0] preg_t;
  typedef logic [rename_params_pkg::fl_bits-1:0] fl_idx_t;

  // ******************************
  // reorder buffer record.
  // ******************************

  // one entry per dispatched instruction.
  // fl_tail is the free list tail before this allocation, the
  // point the free list rewinds to if this entry is the oldest
  // one squashed.
  typedef struct packed {
    areg_t   dest;
    preg_t   new_preg;
    preg_t   told;
    fl_idx_t fl_tail;
  } rob_entry_t;

endpackage

//--- logic/free_list.sv
module free_list (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_en,
  input  logic                      retire_en,
  input  logic                      rollback_en,
  input  rename_types_pkg::areg_t   dest_idx,
  input  rename_types_pkg::preg_t   told_idx,
  input  rename_types_pkg::fl_idx_t rollback_idx,
  output logic                      fl_valid,
  output rename_types_pkg::preg_t   alloc_preg,
  output rename_types_pkg::fl_idx_t alloc_tail
);

  rename_types_pkg::preg_t   fl_table [rename_params_pkg::num_fl];
  rename_types_pkg::fl_idx_t head_q;
  rename_types_pkg::fl_idx_t tail_q;
  logic [rename_params_pkg::fl_bits:0] count_q;
  logic take;
  logic give;
  logic list_empty;

  // freed registers go in at head, new ones leave from tail.
  assign give = retire_en && (told_idx != rename_params_pkg::zero_pr);
  assign take = dispatch_en && (dest_idx != rename_params_pkg::zero_reg);
  assign list_empty = (count_q == '0);

  // an allocation may not run past the next head.
  // with the list empty only a same-cycle free can feed it.
  assign fl_valid = (dest_idx == rename_params_pkg::zero_reg) || !list_empty || give;

  always_comb begin
    if (dest_idx == rename_params_pkg::zero_reg) begin
      alloc_preg = rename_types_pkg::preg_t'(rename_params_pkg::zero_pr);
    end else if (list_empty) begin
      // bypass the register being freed this cycle.
      alloc_preg = told_idx;
    end else begin
      alloc_preg = fl_table[tail_q];
    end
  end

  assign alloc_tail = tail_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= $bits(count_q)'(rename_params_pkg::num_fl);
      for (int i = 0; i < rename_params_pkg::num_fl; i++) begin
        fl_table[i] <= rename_types_pkg::preg_t'(
          rename_params_pkg::num_pr - rename_params_pkg::num_fl + i);
      end
    end else if (rollback_en) begin
      // squashing every in-flight entry returns all of them.
      tail_q  <= rollback_idx;
      count_q <= $bits(count_q)'(rename_params_pkg::num_fl);
    end else begin
      if (give) begin
        fl_table[head_q] <= told_idx;
        head_q <= head_q + 1'b1;
      end
      if (take) begin
        tail_q <= tail_q + 1'b1;
      end
      case ({take, give})
        2'b10: count_q <= count_q - 1'b1;
        2'b01: count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // a rewound tail lands on head, so the list is full again.
  a_rollback_refill: assert property (@(posedge clock) disable iff (reset)
    rollback_en |=> (tail_q == head_q));

endmodule

//--- logic/map_table.sv
module map_table (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  logic                    rollback_en,
  input  rename_types_pkg::areg_t dest_idx,
  input  rename_types_pkg::preg_t alloc_preg,
  input  rename_types_pkg::preg_t [rename_params_pkg::num_ar-1:0] arch_table,
  output rename_types_pkg::preg_t told_preg
);

  rename_types_pkg::preg_t [rename_params_pkg::num_ar-1:0] map_q;
  logic map_write;

  // r0 keeps its identity mapping.
  assign map_write = dispatch_en && (dest_idx != rename_params_pkg::zero_reg);

  // old mapping of the destination.
  assign told_preg = map_q[dest_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_params_pkg::num_ar; i++) begin
        map_q[i] <= rename_types_pkg::preg_t'(i);
      end
    end else if (rollback_en) begin
      // speculative state falls back to the retired state.
      map_q <= arch_table;
    end else if (map_write) begin
      map_q[dest_idx] <= alloc_preg;
    end
  end

  // holds through dispatch and recovery alike.
  a_zero_entry: assert property (@(posedge clock) disable iff (reset)
    map_q[rename_params_pkg::zero_reg] == rename_params_pkg::zero_pr);

endmodule

//--- logic/arch_map.sv
module arch_map (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    retire_en,
  input  rename_types_pkg::areg_t retire_areg,
  input  rename_types_pkg::preg_t retire_preg,
  output rename_types_pkg::preg_t [rename_params_pkg::num_ar-1:0] arch_table
);

  logic arch_write;

  // retired r0 leaves the table alone.
  assign arch_write = retire_en && (retire_areg != rename_params_pkg::zero_reg);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_params_pkg::num_ar; i++) begin
        arch_table[i] <= rename_types_pkg::preg_t'(i);
      end
    end else if (arch_write) begin
      arch_table[retire_areg] <= retire_preg;
    end
  end

endmodule

//--- logic/rename_rob.sv
module rename_rob (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_en,
  input  logic                      retire_en,
  input  logic                      rollback_en,
  input  rename_types_pkg::areg_t   dest_idx,
  input  logic                      fl_valid,
  input  rename_types_pkg::preg_t   alloc_preg,
  input  rename_types_pkg::fl_idx_t alloc_tail,
  input  rename_types_pkg::preg_t   told_preg,
  output logic                      dispatch_fire,
  output logic                      retire_fire,
  output logic                      dispatch_ready,
  output rename_types_pkg::areg_t   retire_areg,
  output rename_types_pkg::preg_t   retire_preg,
  output rename_types_pkg::preg_t   retire_told,
  output rename_types_pkg::fl_idx_t rollback_idx
);

  rename_types_pkg::rob_entry_t ring [rename_params_pkg::rob_depth];
  rename_types_pkg::rob_entry_t new_entry;
  rename_types_pkg::rob_entry_t oldest;
  logic [rename_params_pkg::rob_bits-1:0] head_q;
  logic [rename_params_pkg::rob_bits-1:0] tail_q;
  logic [rename_params_pkg::rob_bits:0]   count_q;
  logic rob_full;
  logic rob_empty;

  assign rob_full  = (count_q == rename_params_pkg::rob_depth);
  assign rob_empty = (count_q == '0);

  // ******************************
  // fire decisions.
  // ******************************

  // rollback wins over everything in its cycle.
  assign dispatch_ready = fl_valid && !rob_full && !rollback_en;
  assign dispatch_fire  = dispatch_en && dispatch_ready;
  assign retire_fire    = retire_en && !rob_empty && !rollback_en;

  // ******************************
  // entry contents.
  // ******************************
  always_comb begin
    new_entry.dest     = dest_idx;
    new_entry.new_preg = alloc_preg;
    new_entry.told     = told_preg;
    new_entry.fl_tail  = alloc_tail;
  end

  assign oldest      = ring[head_q];
  assign retire_areg = oldest.dest;
  assign retire_preg = oldest.new_preg;
  assign retire_told = oldest.told;

  // nothing in flight means tail is already where it belongs.
  assign rollback_idx = rob_empty ? alloc_tail : oldest.fl_tail;

  // payload.
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      ring[tail_q] <= new_entry;
    end
  end

  // pointers and occupancy.
  always_ff @(posedge clock) begin
    if (reset || rollback_en) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (dispatch_fire) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire_fire) begin
        head_q <= head_q + 1'b1;
      end
      case ({dispatch_fire, retire_fire})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // occupancy stays bounded and agrees with the pointer distance.
  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    (count_q <= rename_params_pkg::rob_depth) &&
    ((tail_q - head_q) == count_q[rename_params_pkg::rob_bits-1:0]));

endmodule

//--- logic/rename_unit.sv
module rename_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  rename_types_pkg::areg_t dest_idx,
  input  logic                    retire_en,
  input  logic                    rollback_en,
  output logic                    dispatch_ready,
  output rename_types_pkg::preg_t dispatch_preg,
  output rename_types_pkg::preg_t dispatch_told,
  output logic                    retire_valid,
  output rename_types_pkg::areg_t retire_areg,
  output rename_types_pkg::preg_t retire_preg,
  output rename_types_pkg::preg_t retire_told
);

  logic                      dispatch_fire;
  logic                      fl_valid;
  rename_types_pkg::fl_idx_t alloc_tail;
  rename_types_pkg::fl_idx_t rollback_idx;
  rename_types_pkg::preg_t [rename_params_pkg::num_ar-1:0] arch_table;

  // ******************************
  // control.
  // ******************************
  rename_rob u_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .retire_en      (retire_en),
    .rollback_en    (rollback_en),
    .dest_idx       (dest_idx),
    .fl_valid       (fl_valid),
    .alloc_preg     (dispatch_preg),
    .alloc_tail     (alloc_tail),
    .told_preg      (dispatch_told),
    .dispatch_fire  (dispatch_fire),
    .retire_fire    (retire_valid),
    .dispatch_ready (dispatch_ready),
    .retire_areg    (retire_areg),
    .retire_preg    (retire_preg),
    .retire_told    (retire_told),
    .rollback_idx   (rollback_idx)
  );

  // ******************************
  // state.
  // ******************************
  free_list u_free_list (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_fire),
    .retire_en    (retire_valid),
    .rollback_en  (rollback_en),
    .dest_idx     (dest_idx),
    .told_idx     (retire_told),
    .rollback_idx (rollback_idx),
    .fl_valid     (fl_valid),
    .alloc_preg   (dispatch_preg),
    .alloc_tail   (alloc_tail)
  );

  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_fire),
    .rollback_en (rollback_en),
    .dest_idx    (dest_idx),
    .alloc_preg  (dispatch_preg),
    .arch_table  (arch_table),
    .told_preg   (dispatch_told)
  );

  arch_map u_arch_map (
    .clock       (clock),
    .reset       (reset),
    .retire_en   (retire_valid),
    .retire_areg (retire_areg),
    .retire_preg (retire_preg),
    .arch_table  (arch_table)
  );

endmodule

//--- bench/rename_checker.sv
module rename_checker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  rename_types_pkg::areg_t dest_idx,
  input  logic                    retire_en,
  input  logic                    rollback_en,
  input  logic                    dispatch_ready,
  input  rename_types_pkg::preg_t dispatch_preg,
  input  rename_types_pkg::preg_t dispatch_told,
  input  logic                    retire_valid,
  input  rename_types_pkg::areg_t retire_areg,
  input  rename_types_pkg::preg_t retire_preg,
  input  rename_types_pkg::preg_t retire_told,
  input  logic                    file_active,
  input  logic                    file_ready,
  input  rename_types_pkg::preg_t file_preg,
  input  rename_types_pkg::preg_t file_told,
  input  logic                    file_rvalid,
  input  rename_types_pkg::preg_t file_rpreg,
  input  rename_types_pkg::preg_t file_rtold,
  output int                      model_errors,
  output int                      file_errors
);

  // ******************************
  // reference model state.
  // ******************************
  rename_types_pkg::preg_t spec_map [rename_params_pkg::num_ar];
  rename_types_pkg::preg_t arch_model [rename_params_pkg::num_ar];
  rename_types_pkg::preg_t free_q [$];
  rename_types_pkg::areg_t rob_dest [$];
  rename_types_pkg::preg_t rob_new [$];
  rename_types_pkg::preg_t rob_told [$];

  initial begin
    model_errors = 0;
    file_errors = 0;
  end

  task automatic reset_model();
    free_q.delete();
    rob_dest.delete();
    rob_new.delete();
    rob_told.delete();
    for (int i = 0; i < rename_params_pkg::num_ar; i++) begin
      spec_map[i] = rename_types_pkg::preg_t'(i);
      arch_model[i] = rename_types_pkg::preg_t'(i);
    end
    // upper half of the physical file starts out free.
    for (int i = 0; i < rename_params_pkg::num_fl; i++) begin
      free_q.push_back(rename_types_pkg::preg_t'(
        rename_params_pkg::num_pr - rename_params_pkg::num_fl + i));
    end
  endtask

  task automatic compare_field(input bit from_file, input string name,
                               input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h (%s, time %0t)",
               name, got, exp, from_file ? "stim file" : "model", $time);
      if (from_file) begin
        file_errors++;
      end else begin
        model_errors++;
      end
    end
  endtask

  task automatic check_file();
    compare_field(1'b1, "dispatch_ready", dispatch_ready, file_ready);
    compare_field(1'b1, "retire_valid", retire_valid, file_rvalid);
    if (dispatch_en && file_ready) begin
      compare_field(1'b1, "dispatch_preg", dispatch_preg, file_preg);
      compare_field(1'b1, "dispatch_told", dispatch_told, file_told);
    end
    if (file_rvalid) begin
      compare_field(1'b1, "retire_preg", retire_preg, file_rpreg);
      compare_field(1'b1, "retire_told", retire_told, file_rtold);
    end
  endtask

  task automatic step_model();
    logic exp_retire;
    logic exp_ready;
    logic frees;
    rename_types_pkg::preg_t oldest_told;
    rename_types_pkg::preg_t exp_preg;
    rename_types_pkg::preg_t exp_told;
    oldest_told = (rob_told.size() > 0) ? rob_told[0] : '0;
    exp_retire = retire_en && (rob_dest.size() > 0) && !rollback_en;
    frees = exp_retire && (oldest_told != rename_params_pkg::zero_pr);
    exp_told = spec_map[dest_idx];
    if (dest_idx == rename_params_pkg::zero_reg) begin
      exp_preg = rename_types_pkg::preg_t'(rename_params_pkg::zero_pr);
    end else if (free_q.size() > 0) begin
      exp_preg = free_q[0];
    end else begin
      // empty list, only a freed told can be handed over.
      exp_preg = oldest_told;
    end
    exp_ready = ((dest_idx == rename_params_pkg::zero_reg) || (free_q.size() > 0) || frees)
                && (rob_dest.size() < rename_params_pkg::rob_depth) && !rollback_en;

    compare_field(1'b0, "dispatch_ready", dispatch_ready, exp_ready);
    compare_field(1'b0, "retire_valid", retire_valid, exp_retire);
    if (exp_ready) begin
      compare_field(1'b0, "dispatch_preg", dispatch_preg, exp_preg);
      compare_field(1'b0, "dispatch_told", dispatch_told, exp_told);
    end
    if (exp_retire) begin
      compare_field(1'b0, "retire_areg", retire_areg, rob_dest[0]);
      compare_field(1'b0, "retire_preg", retire_preg, rob_new[0]);
      compare_field(1'b0, "retire_told", retire_told, rob_told[0]);
    end

    if (rollback_en) begin
      // squashed allocations go back in front, oldest first.
      for (int i = rob_new.size() - 1; i >= 0; i--) begin
        if (rob_dest[i] != rename_params_pkg::zero_reg) begin
          free_q.push_front(rob_new[i]);
        end
      end
      spec_map = arch_model;
      rob_dest.delete();
      rob_new.delete();
      rob_told.delete();
    end else begin
      if (exp_retire) begin
        if (rob_dest[0] != rename_params_pkg::zero_reg) begin
          arch_model[rob_dest[0]] = rob_new[0];
        end
        if (frees) begin
          free_q.push_back(oldest_told);
        end
        void'(rob_dest.pop_front());
        void'(rob_new.pop_front());
        void'(rob_told.pop_front());
      end
      if (dispatch_en && exp_ready) begin
        if (dest_idx != rename_params_pkg::zero_reg) begin
          void'(free_q.pop_front());
          spec_map[dest_idx] = exp_preg;
        end
        rob_dest.push_back(dest_idx);
        rob_new.push_back(exp_preg);
        rob_told.push_back(exp_told);
      end
    end
  endtask

  // outputs are sampled before the edge updates any state.
  always @(posedge clock) begin
    if (reset) begin
      reset_model();
    end else begin
      if (file_active) begin
        check_file();
      end
      step_model();
    end
  end

endmodule

//--- bench/rename_tb.sv
module rename_tb;

  typedef struct packed {
    logic                    d_en;
    rename_types_pkg::areg_t dest;
    logic                    r_en;
    logic                    rb_en;
    logic                    e_ready;
    rename_types_pkg::preg_t e_preg;
    rename_types_pkg::preg_t e_told;
    logic                    e_rvalid;
    rename_types_pkg::preg_t e_rpreg;
    rename_types_pkg::preg_t e_rtold;
  } stim_line_t;

  localparam int reset_cycles = 16;
  localparam int random_ops = 300;
  localparam logic [15:0] lfsr_seed = 16'd56802;

  logic                    clock;
  logic                    reset;
  logic                    dispatch_en;
  rename_types_pkg::areg_t dest_idx;
  logic                    retire_en;
  logic                    rollback_en;
  logic                    dispatch_ready;
  rename_types_pkg::preg_t dispatch_preg;
  rename_types_pkg::preg_t dispatch_told;
  logic                    retire_valid;
  rename_types_pkg::areg_t retire_areg;
  rename_types_pkg::preg_t retire_preg;
  rename_types_pkg::preg_t retire_told;

  logic                    file_active;
  logic                    file_ready;
  rename_types_pkg::preg_t file_preg;
  rename_types_pkg::preg_t file_told;
  logic                    file_rvalid;
  rename_types_pkg::preg_t file_rpreg;
  rename_types_pkg::preg_t file_rtold;
  int                      model_errors;
  int                      file_errors;

  stim_line_t  stim_q [$];
  logic [15:0] lfsr_state;
  int          cycle_count;
  int          cycle_limit;
  bit          load_ok;

  rename_unit UUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .dest_idx       (dest_idx),
    .retire_en      (retire_en),
    .rollback_en    (rollback_en),
    .dispatch_ready (dispatch_ready),
    .dispatch_preg  (dispatch_preg),
    .dispatch_told  (dispatch_told),
    .retire_valid   (retire_valid),
    .retire_areg    (retire_areg),
    .retire_preg    (retire_preg),
    .retire_told    (retire_told)
  );

  rename_checker u_checker (
    .clock (clock), .reset (reset),
    .dispatch_en (dispatch_en), .dest_idx (dest_idx),
    .retire_en (retire_en), .rollback_en (rollback_en),
    .dispatch_ready (dispatch_ready), .dispatch_preg (dispatch_preg),
    .dispatch_told (dispatch_told), .retire_valid (retire_valid),
    .retire_areg (retire_areg), .retire_preg (retire_preg), .retire_told (retire_told),
    .file_active (file_active), .file_ready (file_ready),
    .file_preg (file_preg), .file_told (file_told), .file_rvalid (file_rvalid),
    .file_rpreg (file_rpreg), .file_rtold (file_rtold),
    .model_errors (model_errors), .file_errors (file_errors)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ******************************
  // stimulus helpers.
  // ******************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {1'b0, state[15:1]} ^ (state[0] ? 16'hb400 : 16'h0000);
  endfunction

  task automatic draw_bits(input int count, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic drive_idle();
    dispatch_en = 1'b0;
    dest_idx = '0;
    retire_en = 1'b0;
    rollback_en = 1'b0;
    file_active = 1'b0;
    file_ready = 1'b0;
    file_preg = '0;
    file_told = '0;
    file_rvalid = 1'b0;
    file_rpreg = '0;
    file_rtold = '0;
  endtask

  task automatic load_stimulus(output bit ok);
    int fd;
    int fields;
    string text;
    logic [7:0] col [10];
    stim_line_t entry;
    ok = 1'b1;
    fd = $fopen("bench/rename_stim.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() == 0 || text.getc(0) == "#") continue;
      fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                       col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
      if (fields == 10) begin
        entry.d_en = col[0][0];
        entry.dest = rename_types_pkg::areg_t'(col[1]);
        entry.r_en = col[2][0];
        entry.rb_en = col[3][0];
        entry.e_ready = col[4][0];
        entry.e_preg = rename_types_pkg::preg_t'(col[5]);
        entry.e_told = rename_types_pkg::preg_t'(col[6]);
        entry.e_rvalid = col[7][0];
        entry.e_rpreg = rename_types_pkg::preg_t'(col[8]);
        entry.e_rtold = rename_types_pkg::preg_t'(col[9]);
        stim_q.push_back(entry);
      end else if (fields > 0) begin
        $display("malformed stimulus line: %s", text);
        ok = 1'b0;
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) ok = 1'b0;
  endtask

  task automatic run_directed();
    foreach (stim_q[i]) begin
      @(negedge clock);
      dispatch_en = stim_q[i].d_en;
      dest_idx = stim_q[i].dest;
      retire_en = stim_q[i].r_en;
      rollback_en = stim_q[i].rb_en;
      file_ready = stim_q[i].e_ready;
      file_preg = stim_q[i].e_preg;
      file_told = stim_q[i].e_told;
      file_rvalid = stim_q[i].e_rvalid;
      file_rpreg = stim_q[i].e_rpreg;
      file_rtold = stim_q[i].e_rtold;
      file_active = 1'b1;
    end
  endtask

  task automatic run_random();
    logic [15:0] bits;
    for (int n = 0; n < random_ops; n++) begin
      @(negedge clock);
      file_active = 1'b0;
      // dispatch three times in four, so the rob fills now and then.
      draw_bits(2, bits);
      dispatch_en = (bits[1:0] != 2'b00);
      draw_bits(1, bits);
      retire_en = bits[0];
      draw_bits(4, bits);
      rollback_en = (bits[3:0] == 4'hf);
      draw_bits(5, bits);
      dest_idx = rename_types_pkg::areg_t'(bits[4:0]);
    end
  endtask

  // ******************************
  // run control.
  // ******************************
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    lfsr_state = lfsr_seed;
    drive_idle();
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("could not read stimulus from bench/rename_stim.txt");
      $display("Checks failed");
      $finish;
    end else begin
      cycle_limit = (stim_q.size() + random_ops + reset_cycles) * 2;
      repeat (reset_cycles) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      run_directed();
      run_random();
      @(negedge clock);
      drive_idle();
      $display("summary: %0d model mismatches, %0d stim file mismatches, %0d lines, %0d ops",
               model_errors, file_errors, stim_q.size(), random_ops);
      if (model_errors == 0 && file_errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

//--- bench/rename_stim.txt
# columns: dispatch_en dest_idx retire_en rollback_en | expected dispatch_ready
# dispatch_preg dispatch_told retire_valid retire_preg retire_told, all hex
1 05 0 0 1 20 05 0 00 00
1 07 0 0 1 21 07 0 00 00
1 05 0 0 1 22 20 0 00 00
1 00 0 0 1 00 00 0 00 00
1 09 0 0 1 23 09 0 00 00
0 00 1 0 1 00 00 1 20 05
0 00 1 0 1 00 00 1 21 07
1 0a 1 0 1 24 0a 1 22 20
0 00 1 0 1 00 00 1 00 00
0 00 1 0 1 00 00 1 23 09
0 00 1 0 1 00 00 1 24 0a
0 00 1 0 1 00 00 0 00 00
1 01 0 0 1 25 01 0 00 00
1 02 0 0 1 26 02 0 00 00
1 03 0 0 1 27 03 0 00 00
1 04 0 0 1 28 04 0 00 00
1 06 0 0 1 29 06 0 00 00
1 08 0 0 1 2a 08 0 00 00
1 0b 0 0 1 2b 0b 0 00 00
1 0c 0 0 1 2c 0c 0 00 00
1 0d 0 0 0 00 00 0 00 00
1 0d 1 0 0 00 00 1 25 01
1 0d 0 0 1 2d 0d 0 00 00
1 0e 0 1 0 00 00 0 00 00
1 0d 0 0 1 26 0d 0 00 00
1 01 0 0 1 27 25 0 00 00
0 00 1 0 1 00 00 1 26 0d
0 00 0 1 0 00 00 0 00 00
0 00 0 1 0 00 00 0 00 00
1 01 0 0 1 27 25 0 00 00
0 00 1 0 1 00 00 1 27 25
0 00 1 0 1 00 00 0 00 00

//--- project.f
logic/rename_params_pkg.sv
logic/rename_types_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/arch_map.sv
logic/rename_rob.sv
logic/rename_unit.sv
bench/rename_checker.sv
bench/rename_tb.sv
